/* build.f */
rtl/mshr_pkg.sv
rtl/mshr_alloc.sv
rtl/mshr_table.sv
rtl/mshr_fwd_check.sv
rtl/mshr_unit.sv
test/tb_clock.sv
test/tb_mshr_unit.sv

/* run.sh */
#!/usr/bin/env bash
# builds the MSHR testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_mshr_unit \
    -f build.f -o sim_mshr > build.log 2>&1 || { cat build.log; echo "build error"; exit 1; }
./obj_dir/sim_mshr > sim.log 2>&1
cat sim.log
grep -qx "Verification passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

/* test/tb_mshr_unit.sv */
`timescale 1ns/1ps

module tb_mshr_unit;

    // length of the random forward phase
    localparam int fwd_count   = 48;
    // fixed phases plus the random one, used by the watchdog
    localparam int test_cycles = 100 + fwd_count;
    localparam int wait_limit  = 8;

    logic                      clk;
    logic                      rst;
    logic                      req_valid;
    mshr_pkg::l2_set_t         req_set;
    mshr_pkg::l2_tag_t         req_tag;
    mshr_pkg::unstable_state_t req_state;
    logic                      req_ready;
    mshr_pkg::mshr_idx_t       req_idx;
    logic                      upd_valid;
    mshr_pkg::mshr_idx_t       upd_idx;
    mshr_pkg::unstable_state_t upd_state;
    logic                      fwd_valid;
    mshr_pkg::fwd_msg_t        fwd_msg;
    mshr_pkg::l2_set_t         fwd_set;
    mshr_pkg::l2_tag_t         fwd_tag;
    logic                      fwd_done;
    logic                      fwd_hit;
    logic                      fwd_stall;
    mshr_pkg::mshr_idx_t       fwd_idx;
    logic                      drain_req;
    logic                      drain_busy;

    // model of the table, fed from accepted transactions
    mshr_pkg::l2_set_t         m_set   [mshr_pkg::n_mshr];
    mshr_pkg::l2_tag_t         m_tag   [mshr_pkg::n_mshr];
    mshr_pkg::unstable_state_t m_state [mshr_pkg::n_mshr];

    logic [31:0] lfsr_state = 32'h3c3e9f65;
    int          cyc = 0;
    // handshake seen in the last stepped cycle
    logic        accepted;
    logic        ready_seen;
    // expected {hit, stall, idx} and the cycle it is due in
    logic [3:0]  exp_q [$];
    int          due_q [$];

    tb_clock clk0 (.clk(clk), .rst(rst));

    mshr_unit dut0 (.*);

    always @(posedge clk) cyc <= cyc + 1;

    task automatic report_mismatch(input string name, input int expected, input int actual);
        $display("[FAIL] %0t %s expected %0d got %0d", $time, name, expected, actual);
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Verification failed");
        $fatal(1);
    endtask

    // galois form of x^32+x^22+x^2+x+1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    // one lfsr step per bit taken
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return v;
    endfunction

    // any state but spx_i
    function automatic mshr_pkg::unstable_state_t rand_state();
        return mshr_pkg::unstable_state_t'(3'(take_bits(3) % 5 + 1));
    endfunction

    function automatic mshr_pkg::mshr_idx_t highest_free();
        for (int i = mshr_pkg::n_mshr - 1; i >= 0; i--) begin
            if (m_state[i] == mshr_pkg::spx_i) begin
                return mshr_pkg::mshr_idx_t'(i);
            end
        end
        return '0;
    endfunction

    // random start, walk up to a set no live entry holds
    function automatic mshr_pkg::l2_set_t unused_set();
        mshr_pkg::l2_set_t s;
        logic              taken;
        s = mshr_pkg::l2_set_t'(take_bits(mshr_pkg::set_bits));
        for (int k = 0; k < (1 << mshr_pkg::set_bits); k++) begin
            taken = 1'b0;
            for (int i = 0; i < mshr_pkg::n_mshr; i++) begin
                if (m_state[i] != mshr_pkg::spx_i && m_set[i] == s) begin
                    taken = 1'b1;
                end
            end
            if (!taken) begin
                return s;
            end
            s = s + 1'b1;
        end
        return s;
    endfunction

    // ownership or atomic still outstanding
    function automatic logic pending_owner();
        for (int i = 0; i < mshr_pkg::n_mshr; i++) begin
            if (m_state[i] inside {mshr_pkg::spx_xr, mshr_pkg::spx_xrv, mshr_pkg::spx_amo}) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    // expected {hit, stall, idx}, highest live match wins
    function automatic logic [3:0] ref_lookup(input mshr_pkg::l2_set_t s,
                                              input mshr_pkg::l2_tag_t t,
                                              input mshr_pkg::fwd_msg_t msg);
        logic                hit;
        logic                stall;
        mshr_pkg::mshr_idx_t idx;
        hit   = 1'b0;
        stall = 1'b0;
        idx   = '0;
        for (int i = mshr_pkg::n_mshr - 1; i >= 0; i--) begin
            if (!hit && m_state[i] != mshr_pkg::spx_i && m_set[i] == s && m_tag[i] == t) begin
                hit   = 1'b1;
                idx   = mshr_pkg::mshr_idx_t'(i);
                // invalidations and revoked lines go through
                stall = msg != mshr_pkg::fwd_inv && m_state[i] != mshr_pkg::spx_ri;
            end
        end
        return {hit, stall, idx};
    endfunction

    // sample at the falling edge, apply to the model at the rising edge
    task automatic step_cycle();
        logic                      take_req;
        logic                      take_upd;
        logic                      exp_drain;
        mshr_pkg::mshr_idx_t       a_idx;
        mshr_pkg::mshr_idx_t       u_idx;
        mshr_pkg::unstable_state_t u_state;
        @(negedge clk);
        exp_drain = drain_req && pending_owner();
        assert (drain_busy == exp_drain)
            else report_mismatch("drain_busy", int'(exp_drain), int'(drain_busy));
        ready_seen = req_ready;
        take_req   = req_valid && req_ready;
        take_upd   = upd_valid;
        a_idx      = req_idx;
        u_idx      = upd_idx;
        u_state    = upd_state;
        if (take_req) begin
            assert (req_idx == highest_free())
                else report_mismatch("req_idx", int'(highest_free()), int'(req_idx));
        end
        // result uses the states before the coming edge
        if (fwd_valid) begin
            exp_q.push_back(ref_lookup(fwd_set, fwd_tag, fwd_msg));
            due_q.push_back(cyc + 1);
        end
        @(posedge clk);
        if (take_upd) begin
            m_state[u_idx] = u_state;
        end
        if (take_req) begin
            m_set[a_idx]   = req_set;
            m_tag[a_idx]   = req_tag;
            m_state[a_idx] = req_state;
        end
        accepted = take_req;
        #2;
    endtask

    task automatic wait_accept();
        int waited;
        waited   = 0;
        accepted = 1'b0;
        while (!accepted) begin
            if (waited == wait_limit) begin
                abort_run("request was not accepted in time");
            end
            step_cycle();
            waited++;
        end
        req_valid = 1'b0;
    endtask

    task automatic request_miss(input mshr_pkg::l2_set_t s, input mshr_pkg::l2_tag_t t,
                                input mshr_pkg::unstable_state_t st);
        req_valid = 1'b1;
        req_set   = s;
        req_tag   = t;
        req_state = st;
        wait_accept();
    endtask

    task automatic update_entry(input mshr_pkg::mshr_idx_t idx,
                                input mshr_pkg::unstable_state_t st);
        upd_valid = 1'b1;
        upd_idx   = idx;
        upd_state = st;
        step_cycle();
        upd_valid = 1'b0;
    endtask

    task automatic issue_forward(input mshr_pkg::fwd_msg_t msg, input mshr_pkg::l2_set_t s,
                                 input mshr_pkg::l2_tag_t t);
        fwd_valid = 1'b1;
        fwd_msg   = msg;
        fwd_set   = s;
        fwd_tag   = t;
        step_cycle();
        fwd_valid = 1'b0;
    endtask

    // every fwd_done against the model, exactly one cycle after issue
    always @(negedge clk) begin : check_fwd
        logic [3:0] e;
        if (rst) begin
            if (fwd_done) begin
                assert (exp_q.size() > 0 && due_q[0] == cyc)
                    else abort_run("fwd_done pulsed without a forward due in this cycle");
                e = exp_q.pop_front();
                void'(due_q.pop_front());
                assert (fwd_hit == e[3]) else report_mismatch("fwd_hit", e[3], fwd_hit);
                assert (fwd_stall == e[2]) else report_mismatch("fwd_stall", e[2], fwd_stall);
                assert (fwd_idx == e[1:0]) else report_mismatch("fwd_idx", e[1:0], fwd_idx);
            end else begin
                assert (due_q.size() == 0 || due_q[0] != cyc)
                    else abort_run("fwd_done missing one cycle after a forward");
            end
        end
    end

    initial begin : watchdog
        #(test_cycles * 20 + 1000);
        abort_run("timeout, the test did not finish in time");
    end

    initial begin : stimulus
        mshr_pkg::l2_set_t   s;
        mshr_pkg::l2_tag_t   t;
        mshr_pkg::mshr_idx_t v;
        logic [31:0]         r;
        int                  waited;
        req_valid  = 1'b0;
        req_set    = '0;
        req_tag    = '0;
        req_state  = mshr_pkg::spx_is;
        upd_valid  = 1'b0;
        upd_idx    = '0;
        upd_state  = mshr_pkg::spx_is;
        fwd_valid  = 1'b0;
        fwd_msg    = mshr_pkg::fwd_inv;
        fwd_set    = '0;
        fwd_tag    = '0;
        drain_req  = 1'b0;
        accepted   = 1'b0;
        ready_seen = 1'b0;
        for (int i = 0; i < mshr_pkg::n_mshr; i++) begin
            m_set[i]   = '0;
            m_tag[i]   = '0;
            m_state[i] = mshr_pkg::spx_i;
        end
        wait (rst === 1'b1);
        @(posedge clk);
        #2;

        // fill all entries with distinct sets
        for (int k = 0; k < mshr_pkg::n_mshr; k++) begin
            request_miss(unused_set(), mshr_pkg::l2_tag_t'(take_bits(8)), rand_state());
        end
        // out of credits
        req_set = unused_set();
        for (int k = 0; k < 3; k++) begin
            step_cycle();
            assert (!ready_seen) else report_mismatch("req_ready", 0, int'(ready_seen));
        end

        // free entry 0, credit back within three cycles
        s = m_set[0];
        t = m_tag[0];
        update_entry(2'd0, mshr_pkg::spx_i);
        waited = 0;
        ready_seen = 1'b0;
        while (!ready_seen) begin
            if (waited == 3) begin
                abort_run("req_ready did not rise within three cycles after a free");
            end
            step_cycle();
            waited++;
        end
        // freed line must miss now
        issue_forward(mshr_pkg::fwd_req_s, s, t);

        // same set as live entry 3 waits until that entry is freed
        req_valid = 1'b1;
        req_set   = m_set[3];
        req_tag   = mshr_pkg::l2_tag_t'(take_bits(8));
        req_state = rand_state();
        for (int k = 0; k < 3; k++) begin
            step_cycle();
            assert (!ready_seen) else report_mismatch("req_ready", 0, int'(ready_seen));
        end
        update_entry(2'd3, mshr_pkg::spx_i);
        wait_accept();
        // refill, all entries live again
        request_miss(unused_set(), mshr_pkg::l2_tag_t'(take_bits(8)), rand_state());

        // stall exemptions, revoked line and a pending ownership
        update_entry(2'd1, mshr_pkg::spx_ri);
        update_entry(2'd2, mshr_pkg::spx_xr);
        drain_req = 1'b1;
        for (int m = 0; m < 4; m++) begin
            issue_forward(mshr_pkg::fwd_msg_t'(2'(m)), m_set[1], m_tag[1]);
            issue_forward(mshr_pkg::fwd_msg_t'(2'(m)), m_set[2], m_tag[2]);
        end

        // back to back random forwards, state churn and drain toggling
        for (int n = 0; n < fwd_count; n++) begin
            r = take_bits(1);
            drain_req = r[0];
            r = take_bits(2);
            if (r[1:0] == 2'b00) begin
                upd_valid = 1'b1;
                upd_idx   = mshr_pkg::mshr_idx_t'(take_bits(2));
                upd_state = rand_state();
            end
            r = take_bits(1);
            v = mshr_pkg::mshr_idx_t'(take_bits(2));
            s = r[0] ? m_set[v] : mshr_pkg::l2_set_t'(take_bits(4));
            t = r[0] ? m_tag[v] : mshr_pkg::l2_tag_t'(take_bits(8));
            issue_forward(mshr_pkg::fwd_msg_t'(2'(take_bits(2))), s, t);
            upd_valid = 1'b0;
        end
        drain_req = 1'b0;

        repeat (3) step_cycle();
        if (exp_q.size() == 0) begin
            $display("Verification passed");
            $finish;
        end else begin
            abort_run("forward results still outstanding at the end of the test");
        end
    end

endmodule

/* test/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
    output logic clk,
    output logic rst
);

    // 20 ns period
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // reset low over the first two rising edges
    initial begin
        rst = 1'b0;
        repeat (2) @(posedge clk);
        #2 rst = 1'b1;
    end

endmodule

/* rtl/mshr_unit.sv */
`timescale 1ns/1ps

module mshr_unit (
    input  logic                        clk,
    input  logic                        rst,
    // new miss
    input  logic                        req_valid,
    input  mshr_pkg::l2_set_t           req_set,
    input  mshr_pkg::l2_tag_t           req_tag,
    input  mshr_pkg::unstable_state_t   req_state,
    output logic                        req_ready,
    output mshr_pkg::mshr_idx_t         req_idx,
    // state update
    input  logic                        upd_valid,
    input  mshr_pkg::mshr_idx_t         upd_idx,
    input  mshr_pkg::unstable_state_t   upd_state,
    // forward lookup
    input  logic                        fwd_valid,
    input  mshr_pkg::fwd_msg_t          fwd_msg,
    input  mshr_pkg::l2_set_t           fwd_set,
    input  mshr_pkg::l2_tag_t           fwd_tag,
    output logic                        fwd_done,
    output logic                        fwd_hit,
    output logic                        fwd_stall,
    output mshr_pkg::mshr_idx_t         fwd_idx,
    // drain
    input  logic                        drain_req,
    output logic                        drain_busy
);

    // allocator and table handshake
    logic alloc_we;
    logic set_conflict;
    logic credit_return;

    // table contents to the forward checker
    mshr_pkg::l2_set_t         entry_set   [mshr_pkg::n_mshr];
    mshr_pkg::l2_tag_t         entry_tag   [mshr_pkg::n_mshr];
    mshr_pkg::unstable_state_t entry_state [mshr_pkg::n_mshr];

    // credits and acceptance
    mshr_alloc alloc0 (
        .clk           (clk),
        .rst           (rst),
        .req_valid     (req_valid),
        .set_conflict  (set_conflict),
        .credit_return (credit_return),
        .req_ready     (req_ready),
        .alloc_we      (alloc_we)
    );

    // entry storage, free index goes straight out as req_idx
    mshr_table table0 (
        .clk           (clk),
        .rst           (rst),
        .alloc_we      (alloc_we),
        .req_set       (req_set),
        .req_tag       (req_tag),
        .req_state     (req_state),
        .upd_valid     (upd_valid),
        .upd_idx       (upd_idx),
        .upd_state     (upd_state),
        .drain_req     (drain_req),
        .free_idx      (req_idx),
        .set_conflict  (set_conflict),
        .credit_return (credit_return),
        .drain_busy    (drain_busy),
        .entry_set     (entry_set),
        .entry_tag     (entry_tag),
        .entry_state   (entry_state)
    );

    // forward lookup and stall
    mshr_fwd_check fwd0 (
        .clk         (clk),
        .rst         (rst),
        .fwd_valid   (fwd_valid),
        .fwd_msg     (fwd_msg),
        .fwd_set     (fwd_set),
        .fwd_tag     (fwd_tag),
        .entry_set   (entry_set),
        .entry_tag   (entry_tag),
        .entry_state (entry_state),
        .fwd_done    (fwd_done),
        .fwd_hit     (fwd_hit),
        .fwd_stall   (fwd_stall),
        .fwd_idx     (fwd_idx)
    );

endmodule

/* rtl/mshr_fwd_check.sv */
`timescale 1ns/1ps

module mshr_fwd_check (
    input  logic                        clk,
    input  logic                        rst,
    // incoming forward from the directory
    input  logic                        fwd_valid,
    input  mshr_pkg::fwd_msg_t          fwd_msg,
    input  mshr_pkg::l2_set_t           fwd_set,
    input  mshr_pkg::l2_tag_t           fwd_tag,
    // current table contents
    input  mshr_pkg::l2_set_t           entry_set   [mshr_pkg::n_mshr],
    input  mshr_pkg::l2_tag_t           entry_tag   [mshr_pkg::n_mshr],
    input  mshr_pkg::unstable_state_t   entry_state [mshr_pkg::n_mshr],
    // lookup result, one cycle after fwd_valid
    output logic                        fwd_done,
    output logic                        fwd_hit,
    output logic                        fwd_stall,
    output mshr_pkg::mshr_idx_t         fwd_idx
);

    logic                      hit_next;
    logic                      stall_next;
    mshr_pkg::mshr_idx_t       idx_next;
    // state of the winning entry
    mshr_pkg::unstable_state_t hit_state;

    // match against live entries
    // later index overrides, highest match wins
    always_comb begin
        hit_next  = 1'b0;
        idx_next  = '0;
        hit_state = mshr_pkg::spx_i;
        for (int i = 0; i < mshr_pkg::n_mshr; i++) begin
            if (entry_state[i] != mshr_pkg::spx_i &&
                entry_set[i] == fwd_set && entry_tag[i] == fwd_tag) begin
                hit_next  = 1'b1;
                idx_next  = mshr_pkg::mshr_idx_t'(i);
                hit_state = entry_state[i];
            end
        end
    end

    // stall rule
    // fwd_inv is always answered right away
    // others pass only if ownership is already being revoked
    assign stall_next = hit_next && fwd_msg != mshr_pkg::fwd_inv &&
                        hit_state != mshr_pkg::spx_ri;

    // result register, new lookup every cycle
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            fwd_done  <= 1'b0;
            fwd_hit   <= 1'b0;
            fwd_stall <= 1'b0;
            fwd_idx   <= '0;
        end else begin
            fwd_done  <= fwd_valid;
            fwd_hit   <= fwd_valid && hit_next;
            fwd_stall <= fwd_valid && stall_next;
            // miss reports index 0
            fwd_idx   <= (fwd_valid && hit_next) ? idx_next : '0;
        end
    end

    // a stall always points at a real entry
    stall_hit_a: assert property (
        @(posedge clk) disable iff (!rst)
        fwd_stall |-> (fwd_hit && fwd_done)
    );

endmodule

/* rtl/mshr_table.sv */
`timescale 1ns/1ps

module mshr_table (
    input  logic                        clk,
    input  logic                        rst,
    // allocation of a new miss at free_idx
    input  logic                        alloc_we,
    input  mshr_pkg::l2_set_t           req_set,
    input  mshr_pkg::l2_tag_t           req_tag,
    input  mshr_pkg::unstable_state_t   req_state,
    // state update of a live entry
    input  logic                        upd_valid,
    input  mshr_pkg::mshr_idx_t         upd_idx,
    input  mshr_pkg::unstable_state_t   upd_state,
    input  logic                        drain_req,
    output mshr_pkg::mshr_idx_t         free_idx,
    output logic                        set_conflict,
    output logic                        credit_return,
    output logic                        drain_busy,
    // entry contents for the forward checker
    output mshr_pkg::l2_set_t           entry_set   [mshr_pkg::n_mshr],
    output mshr_pkg::l2_tag_t           entry_tag   [mshr_pkg::n_mshr],
    output mshr_pkg::unstable_state_t   entry_state [mshr_pkg::n_mshr]
);

    // live flags now and one cycle ago
    logic [mshr_pkg::n_mshr-1:0] live;
    logic [mshr_pkg::n_mshr-1:0] live_q;
    // any entry free at all
    logic free_any;

    // set and tag are payload, only meaningful while the entry is live
    always_ff @(posedge clk) begin
        if (alloc_we) begin
            entry_set[free_idx] <= req_set;
            entry_tag[free_idx] <= req_tag;
        end
    end

    // state per entry
    // allocation writes the initial state, update overwrites it
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int i = 0; i < mshr_pkg::n_mshr; i++) begin
                entry_state[i] <= mshr_pkg::spx_i;
            end
        end else begin
            for (int i = 0; i < mshr_pkg::n_mshr; i++) begin
                if (alloc_we && free_idx == mshr_pkg::mshr_idx_t'(i)) begin
                    entry_state[i] <= req_state;
                end else if (upd_valid && upd_idx == mshr_pkg::mshr_idx_t'(i)) begin
                    entry_state[i] <= upd_state;
                end
            end
        end
    end

    // scan for free slot, set conflict and outstanding ownership
    always_comb begin
        free_idx     = '0;
        free_any     = 1'b0;
        set_conflict = 1'b0;
        drain_busy   = 1'b0;
        for (int i = 0; i < mshr_pkg::n_mshr; i++) begin
            live[i] = entry_state[i] != mshr_pkg::spx_i;
            // ascending loop, so the highest free index wins
            if (!live[i]) begin
                free_idx = mshr_pkg::mshr_idx_t'(i);
                free_any = 1'b1;
            end
            // same set already in flight, new miss has to wait
            if (live[i] && entry_set[i] == req_set) begin
                set_conflict = 1'b1;
            end
            // ownership or atomic still pending
            if (drain_req && (entry_state[i] == mshr_pkg::spx_xr ||
                              entry_state[i] == mshr_pkg::spx_xrv ||
                              entry_state[i] == mshr_pkg::spx_amo)) begin
                drain_busy = 1'b1;
            end
        end
    end

    // credit return
    // live last cycle and free now means an entry was just released,
    // the pulse comes out one cycle after the entry went to spx_i
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            live_q        <= '0;
            credit_return <= 1'b0;
        end else begin
            live_q        <= live;
            credit_return <= |(live_q & ~live);
        end
    end

    // allocator granted a credit, so a free entry must exist
    alloc_free_a: assert property (
        @(posedge clk) disable iff (!rst)
        alloc_we |-> free_any
    );

    // updates go to entries that are in flight
    upd_live_a: assert property (
        @(posedge clk) disable iff (!rst)
        upd_valid |-> entry_state[upd_idx] != mshr_pkg::spx_i
    );

    // never allocate and update the same slot on one edge
    no_clash_a: assert property (
        @(posedge clk) disable iff (!rst)
        (alloc_we && upd_valid) |-> upd_idx != free_idx
    );

endmodule

/* rtl/mshr_alloc.sv */
`timescale 1ns/1ps

module mshr_alloc (
    input  logic clk,
    input  logic rst,
    // new miss from the l2 controller
    input  logic req_valid,
    // some live entry already holds the requested set
    input  logic set_conflict,
    // one entry was freed, one credit comes back
    input  logic credit_return,
    output logic req_ready,
    output logic alloc_we
);

    // one credit per free entry
    logic [mshr_pkg::credit_bits-1:0] credits;

    // accept only with a credit in hand and no set conflict
    assign req_ready = (credits != '0) && !set_conflict;

    // table writes the new entry on this strobe
    assign alloc_we = req_valid && req_ready;

    // credit counter
    // take on allocation, give back on return, both at once cancel
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            credits <= mshr_pkg::credit_bits'(mshr_pkg::n_mshr);
        end else begin
            case ({alloc_we, credit_return})
                2'b10: begin
                    credits <= credits - 1'b1;
                end
                2'b01: begin
                    credits <= credits + 1'b1;
                end
                default: begin
                    credits <= credits;
                end
            endcase
        end
    end

    // counter stays within 0..n_mshr
    // an underflow would wrap above n_mshr and trip this as well
    credit_range_a: assert property (
        @(posedge clk) disable iff (!rst)
        credits <= mshr_pkg::credit_bits'(mshr_pkg::n_mshr)
    );

    // table never hands back a credit the allocator did not give out
    credit_return_a: assert property (
        @(posedge clk) disable iff (!rst)
        (credit_return && !alloc_we) |->
            credits != mshr_pkg::credit_bits'(mshr_pkg::n_mshr)
    );

endmodule

/* rtl/mshr_pkg.sv */
package mshr_pkg;

    // table geometry
    localparam int n_mshr = 4;
    // index width for n_mshr entries
    localparam int mshr_bits = 2;

    // l2 address fields kept per entry
    localparam int set_bits = 4;
    localparam int tag_bits = 8;

    // credit counter holds 0 through n_mshr
    localparam int credit_bits = 3;

    // entry index
    typedef logic [mshr_bits-1:0] mshr_idx_t;

    // cache set index
    typedef logic [set_bits-1:0] l2_set_t;

    // cache tag
    typedef logic [tag_bits-1:0] l2_tag_t;

    // transient coherence states of a pending miss
    // spx_i must stay at zero, it marks a free entry
    typedef enum logic [2:0] {
        spx_i   = 3'd0,
        spx_is  = 3'd1,
        spx_ri  = 3'd2,
        spx_xr  = 3'd3,
        spx_xrv = 3'd4,
        spx_amo = 3'd5
    } unstable_state_t;

    // forwarded coherence messages from the directory
    typedef enum logic [1:0] {
        fwd_inv       = 2'd0,
        fwd_rvk_o     = 2'd1,
        fwd_req_s     = 2'd2,
        fwd_req_odata = 2'd3
    } fwd_msg_t;

endpackage
